// File: Bender.yml
package:
  name: fir_interp

sources:
  - rtl/fir_pkg.sv
  - rtl/sample_ram.sv
  - rtl/fir_coef_rom.sv
  - rtl/dsp_mac.sv
  - rtl/fir_interp_seq.sv
  - rtl/fir_interp_top.sv
  - target: test
    files:
      - testbench/fir_interp_tb.sv

// File: rtl/dsp_mac.sv
// Two-stage signed multiply-accumulate slice with clear and accumulate opmodes
module dsp_mac (
    input  logic                                clk,
    input  logic                                reset,
    input  fir_pkg::dsp_opmode_e                opmode,
    input  logic signed [fir_pkg::sample_w-1:0] a,
    input  logic signed [fir_pkg::sample_w-1:0] b,
    output logic signed [fir_pkg::acc_w-1:0]    acc
);

    fir_pkg::dsp_opmode_e                  opmode_q;
    logic signed [fir_pkg::sample_w-1:0]   a_q;
    logic signed [fir_pkg::sample_w-1:0]   b_q;
    logic signed [2*fir_pkg::sample_w-1:0] prod;

    // Stage one, input registers
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            opmode_q <= fir_pkg::dsp_clear;
        end else begin
            opmode_q <= opmode;
        end
    end

    always_ff @(posedge clk) begin
        a_q <= a;
        b_q <= b;
    end

    assign prod = a_q * b_q;

    // Stage two, accumulator
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            acc <= '0;
        end else if (opmode_q == fir_pkg::dsp_clear) begin
            acc <= '0;
        end else begin
            acc <= acc + prod;
        end
    end

    a_opmode_known: assert property (
        @(posedge clk) disable iff (reset) !$isunknown(opmode)
    ) else $error("slice opmode unknown");

endmodule

// File: rtl/fir_coef_rom.sv
// Symmetric 34-tap low-pass coefficient table shared by both channels
module fir_coef_rom (
    input  logic [fir_pkg::addr_w-1:0]          idx,
    output logic signed [fir_pkg::sample_w-1:0] coef
);

    always_comb begin
        case (idx)
            // First half, rising towards the main lobe
            6'd0:    coef = 18'h3FFF8;
            6'd1:    coef = 18'h3FFE8;
            6'd2:    coef = 18'h3FFD0;
            6'd3:    coef = 18'h3FFC4;
            6'd4:    coef = 18'h3FFD8;
            6'd5:    coef = 18'h00040;
            6'd6:    coef = 18'h000B0;
            6'd7:    coef = 18'h000E4;
            6'd8:    coef = 18'h000A8;
            6'd9:    coef = 18'h3FFC0;
            6'd10:   coef = 18'h3FE50;
            6'd11:   coef = 18'h3FD10;
            6'd12:   coef = 18'h3FD60;
            6'd13:   coef = 18'h00120;
            6'd14:   coef = 18'h00A40;
            6'd15:   coef = 18'h01C80;
            6'd16:   coef = 18'h02B10;

            // Mirror image
            6'd17:   coef = 18'h02B10;
            6'd18:   coef = 18'h01C80;
            6'd19:   coef = 18'h00A40;
            6'd20:   coef = 18'h00120;
            6'd21:   coef = 18'h3FD60;
            6'd22:   coef = 18'h3FD10;
            6'd23:   coef = 18'h3FE50;
            6'd24:   coef = 18'h3FFC0;
            6'd25:   coef = 18'h000A8;
            6'd26:   coef = 18'h000E4;
            6'd27:   coef = 18'h000B0;
            6'd28:   coef = 18'h00040;
            6'd29:   coef = 18'h3FFD8;
            6'd30:   coef = 18'h3FFC4;
            6'd31:   coef = 18'h3FFD0;
            6'd32:   coef = 18'h3FFE8;
            6'd33:   coef = 18'h3FFF8;

            default: coef = 18'h00000;
        endcase
    end

endmodule

// File: rtl/fir_interp_seq.sv
// Microcoded FIR sequencer with delay-line addressing, slice control and output register
module fir_interp_seq (
    input  logic                                  clk,
    input  logic                                  reset,

    input  logic                                  sample_in_rdy,
    input  logic signed [fir_pkg::sample_w-1:0]   sample_in_l,
    input  logic signed [fir_pkg::sample_w-1:0]   sample_in_r,

    output logic                                  xbuf_wr,
    output logic [fir_pkg::addr_w-1:0]            xbuf_wr_addr,
    output logic [2*fir_pkg::sample_w-1:0]        xbuf_wr_data,
    output logic [fir_pkg::addr_w-1:0]            xbuf_rd_addr,
    input  logic [2*fir_pkg::sample_w-1:0]        xbuf_rd_data,

    output logic [fir_pkg::addr_w-1:0]            coef_idx,
    input  logic signed [fir_pkg::sample_w-1:0]   coef,

    output fir_pkg::dsp_opmode_e                  dsp_opmode,
    output logic signed [fir_pkg::sample_w-1:0]   dsp_coef,
    output logic signed [fir_pkg::sample_w-1:0]   dsp_x_l,
    output logic signed [fir_pkg::sample_w-1:0]   dsp_x_r,
    input  logic signed [fir_pkg::acc_w-1:0]      dsp_acc_l,
    input  logic signed [fir_pkg::acc_w-1:0]      dsp_acc_r,

    output logic                                  sample_out_rdy,
    output logic signed [fir_pkg::sample_w-1:0]   sample_out_l,
    output logic signed [fir_pkg::sample_w-1:0]   sample_out_r
);

    fir_pkg::seq_step_e                  step;
    fir_pkg::seq_step_e                  step_nxt;
    logic signed [fir_pkg::sample_w-1:0] in_l;
    logic signed [fir_pkg::sample_w-1:0] in_r;
    logic signed [fir_pkg::sample_w-1:0] x_rd_l;
    logic signed [fir_pkg::sample_w-1:0] x_rd_r;
    logic [fir_pkg::addr_w-1:0]          rpt_cnt;
    logic [fir_pkg::addr_w-1:0]          tap_idx;
    logic [fir_pkg::addr_w-1:0]          head;
    logic [fir_pkg::addr_w-1:0]          rd_ptr;
    logic [fir_pkg::addr_w-1:0]          mid_addr;
    logic                                repeat_step;
    logic                                rpt_last;

    always_ff @(posedge clk) begin
        if (sample_in_rdy) begin
            in_l <= sample_in_l;
            in_r <= sample_in_r;
        end
    end

    // ------------------------------------------------------------------------
    // Step register and repeat counter
    // ------------------------------------------------------------------------
    assign repeat_step = (step == fir_pkg::seq_init_push) || (step == fir_pkg::seq_mac);
    assign rpt_last    = (rpt_cnt == fir_pkg::addr_t'(fir_pkg::num_taps - 1));

    always_comb begin
        case (step)
            fir_pkg::seq_clear_i:   step_nxt = fir_pkg::seq_init_push;
            fir_pkg::seq_init_push: step_nxt = rpt_last ? fir_pkg::seq_wait_in
                                                        : fir_pkg::seq_init_push;
            fir_pkg::seq_wait_in:   step_nxt = sample_in_rdy ? fir_pkg::seq_push
                                                             : fir_pkg::seq_wait_in;
            fir_pkg::seq_push:      step_nxt = fir_pkg::seq_mac;
            fir_pkg::seq_mac:       step_nxt = rpt_last ? fir_pkg::seq_drain_0
                                                        : fir_pkg::seq_mac;
            fir_pkg::seq_drain_0:   step_nxt = fir_pkg::seq_drain_1;
            fir_pkg::seq_drain_1:   step_nxt = fir_pkg::seq_out_acc;
            fir_pkg::seq_out_acc:   step_nxt = fir_pkg::seq_out_mid;
            fir_pkg::seq_out_mid:   step_nxt = fir_pkg::seq_loop;
            fir_pkg::seq_loop:      step_nxt = fir_pkg::seq_wait_in;
            default:                step_nxt = fir_pkg::seq_clear_i;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            step    <= fir_pkg::seq_clear_i;
            rpt_cnt <= '0;
        end else begin
            step <= step_nxt;
            if (repeat_step && !rpt_last) begin
                rpt_cnt <= rpt_cnt + 1'b1;
            end else begin
                rpt_cnt <= '0;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Tap index, head and read pointer
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tap_idx <= '0;
            head    <= '0;
            rd_ptr  <= '0;
        end else begin
            if (step == fir_pkg::seq_clear_i || step == fir_pkg::seq_push) begin
                tap_idx <= '0;
            end else if (step == fir_pkg::seq_mac) begin
                tap_idx <= tap_idx + 1'b1;
            end

            // Head walks down, newest sample sits at rd_ptr after the push
            if (xbuf_wr) begin
                head <= (head == '0) ? fir_pkg::addr_t'(fir_pkg::num_taps - 1)
                                     : head - 1'b1;
            end

            if (step == fir_pkg::seq_push) begin
                rd_ptr <= head;
            end else if (step == fir_pkg::seq_mac) begin
                rd_ptr <= (rd_ptr == fir_pkg::addr_t'(fir_pkg::num_taps - 1)) ? '0
                                                                              : rd_ptr + 1'b1;
            end
        end
    end

    // 34 increments bring rd_ptr back to the newest sample
    assign mid_addr = (rd_ptr >= fir_pkg::addr_t'(fir_pkg::num_taps - fir_pkg::mid_offset))
                    ? rd_ptr - fir_pkg::addr_t'(fir_pkg::num_taps - fir_pkg::mid_offset)
                    : rd_ptr + fir_pkg::addr_t'(fir_pkg::mid_offset);

    assign xbuf_wr      = (step == fir_pkg::seq_init_push) || (step == fir_pkg::seq_push);
    assign xbuf_wr_addr = head;
    assign xbuf_wr_data = (step == fir_pkg::seq_init_push) ? '0 : {in_l, in_r};
    assign xbuf_rd_addr = (step == fir_pkg::seq_out_mid) ? mid_addr : rd_ptr;
    assign coef_idx     = tap_idx;

    assign x_rd_l = xbuf_rd_data[2*fir_pkg::sample_w-1:fir_pkg::sample_w];
    assign x_rd_r = xbuf_rd_data[fir_pkg::sample_w-1:0];

    // ------------------------------------------------------------------------
    // Slice control, one register stage ahead of the slices
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dsp_opmode <= fir_pkg::dsp_clear;
        end else begin
            dsp_opmode <= (step == fir_pkg::seq_mac) ? fir_pkg::dsp_mac : fir_pkg::dsp_clear;
        end
    end

    always_ff @(posedge clk) begin
        dsp_coef <= coef;
        dsp_x_l  <= x_rd_l;
        dsp_x_r  <= x_rd_r;
    end

    // Filtered result, then half of the middle sample
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sample_out_rdy <= 1'b0;
            sample_out_l   <= '0;
            sample_out_r   <= '0;
        end else if (step == fir_pkg::seq_out_acc) begin
            sample_out_rdy <= 1'b1;
            sample_out_l   <= dsp_acc_l[fir_pkg::out_lsb +: fir_pkg::sample_w];
            sample_out_r   <= dsp_acc_r[fir_pkg::out_lsb +: fir_pkg::sample_w];
        end else if (step == fir_pkg::seq_out_mid) begin
            sample_out_rdy <= 1'b1;
            sample_out_l   <= x_rd_l >>> 1;
            sample_out_r   <= x_rd_r >>> 1;
        end else begin
            sample_out_rdy <= 1'b0;
            sample_out_l   <= '0;
            sample_out_r   <= '0;
        end
    end

    // Two output strobes per input, never a third
    a_out_burst: assert property (
        @(posedge clk) disable iff (reset)
        sample_out_rdy ##1 sample_out_rdy |=> !sample_out_rdy
    ) else $error("output strobe high three cycles in a row");

    a_mac_length: assert property (
        @(posedge clk) disable iff (reset)
        $rose(step == fir_pkg::seq_mac) |-> ##(fir_pkg::num_taps) (step != fir_pkg::seq_mac)
    ) else $error("MAC phase longer than %0d cycles", fir_pkg::num_taps);

endmodule

// File: rtl/fir_interp_top.sv
// Stereo FIR stage top: sequencer, delay line, coefficient table and two MAC slices
module fir_interp_top (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                sample_in_rdy,
    input  logic signed [fir_pkg::sample_w-1:0] sample_in_l,
    input  logic signed [fir_pkg::sample_w-1:0] sample_in_r,
    output logic                                sample_out_rdy,
    output logic signed [fir_pkg::sample_w-1:0] sample_out_l,
    output logic signed [fir_pkg::sample_w-1:0] sample_out_r
);

    logic                                xbuf_wr;
    logic [fir_pkg::addr_w-1:0]          xbuf_wr_addr;
    logic [2*fir_pkg::sample_w-1:0]      xbuf_wr_data;
    logic [fir_pkg::addr_w-1:0]          xbuf_rd_addr;
    logic [2*fir_pkg::sample_w-1:0]      xbuf_rd_data;
    logic [fir_pkg::addr_w-1:0]          coef_idx;
    logic signed [fir_pkg::sample_w-1:0] coef;
    fir_pkg::dsp_opmode_e                dsp_opmode;
    logic signed [fir_pkg::sample_w-1:0] dsp_coef;
    logic signed [fir_pkg::sample_w-1:0] dsp_x_l;
    logic signed [fir_pkg::sample_w-1:0] dsp_x_r;
    logic signed [fir_pkg::acc_w-1:0]    dsp_acc_l;
    logic signed [fir_pkg::acc_w-1:0]    dsp_acc_r;

    fir_interp_seq u_seq (
        .clk            (clk),
        .reset          (reset),
        .sample_in_rdy  (sample_in_rdy),
        .sample_in_l    (sample_in_l),
        .sample_in_r    (sample_in_r),
        .xbuf_wr        (xbuf_wr),
        .xbuf_wr_addr   (xbuf_wr_addr),
        .xbuf_wr_data   (xbuf_wr_data),
        .xbuf_rd_addr   (xbuf_rd_addr),
        .xbuf_rd_data   (xbuf_rd_data),
        .coef_idx       (coef_idx),
        .coef           (coef),
        .dsp_opmode     (dsp_opmode),
        .dsp_coef       (dsp_coef),
        .dsp_x_l        (dsp_x_l),
        .dsp_x_r        (dsp_x_r),
        .dsp_acc_l      (dsp_acc_l),
        .dsp_acc_r      (dsp_acc_r),
        .sample_out_rdy (sample_out_rdy),
        .sample_out_l   (sample_out_l),
        .sample_out_r   (sample_out_r)
    );

    sample_ram u_xbuf (
        .clk     (clk),
        .wr      (xbuf_wr),
        .wr_addr (xbuf_wr_addr),
        .wr_data (xbuf_wr_data),
        .rd_addr (xbuf_rd_addr),
        .rd_data (xbuf_rd_data)
    );

    fir_coef_rom u_coef (
        .idx  (coef_idx),
        .coef (coef)
    );

    // Same taps on both channels
    dsp_mac u_mac_l (
        .clk    (clk),
        .reset  (reset),
        .opmode (dsp_opmode),
        .a      (dsp_coef),
        .b      (dsp_x_l),
        .acc    (dsp_acc_l)
    );

    dsp_mac u_mac_r (
        .clk    (clk),
        .reset  (reset),
        .opmode (dsp_opmode),
        .a      (dsp_coef),
        .b      (dsp_x_r),
        .acc    (dsp_acc_r)
    );

endmodule

// File: rtl/fir_pkg.sv
// Shared FIR widths, tap count, output scaling, address type, slice opmode and step enums
package fir_pkg;

    // ------------------------------------------------------------------------
    // Data path sizes
    // ------------------------------------------------------------------------
    localparam int sample_w   = 18;
    localparam int num_taps   = 34;
    localparam int addr_w     = 6;
    localparam int acc_w      = 48;

    // Output takes acc[out_lsb+sample_w-1:out_lsb]
    localparam int out_lsb    = 16;

    // Newest sample to middle of the delay line
    localparam int mid_offset = num_taps / 2 - 1;

    typedef logic [addr_w-1:0] addr_t;

    // ------------------------------------------------------------------------
    // Enums
    // ------------------------------------------------------------------------
    typedef enum logic [0:0] {
        dsp_clear,
        dsp_mac
    } dsp_opmode_e;

    typedef enum logic [3:0] {
        seq_clear_i,
        seq_init_push,
        seq_wait_in,
        seq_push,
        seq_mac,
        seq_drain_0,
        seq_drain_1,
        seq_out_acc,
        seq_out_mid,
        seq_loop
    } seq_step_e;

endpackage

// File: rtl/sample_ram.sv
// Stereo delay-line memory, registered write port and combinational read port
module sample_ram (
    input  logic                            clk,
    input  logic                            wr,
    input  logic [fir_pkg::addr_w-1:0]      wr_addr,
    input  logic [2*fir_pkg::sample_w-1:0]  wr_data,
    input  logic [fir_pkg::addr_w-1:0]      rd_addr,
    output logic [2*fir_pkg::sample_w-1:0]  rd_data
);

    // Left sample in the upper half, right in the lower
    logic [2*fir_pkg::sample_w-1:0] mem [fir_pkg::num_taps];

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_addr] <= wr_data;
        end
    end

    assign rd_data = mem[rd_addr];

    // Head pointer wraps inside the 34 entries
    a_wr_addr_range: assert property (
        @(posedge clk) wr |-> (wr_addr < fir_pkg::addr_t'(fir_pkg::num_taps))
    ) else $error("delay line write outside %0d entries", fir_pkg::num_taps);

endmodule

// File: tb.f
rtl/fir_pkg.sv
rtl/sample_ram.sv
rtl/fir_coef_rom.sv
rtl/dsp_mac.sv
rtl/fir_interp_seq.sv
rtl/fir_interp_top.sv
testbench/fir_interp_tb.sv

// File: testbench/fir_interp_tb.sv
// Testbench for the stereo FIR stage: clock, reset, file-driven stimulus, output checks, watchdog
module fir_interp_tb;

    localparam int clk_period       = 40;
    localparam int num_records      = 42;
    localparam int rec_words        = 6;
    localparam int exp_latency      = fir_pkg::num_taps + 4;
    localparam int max_latency      = 3 * fir_pkg::num_taps;
    localparam int watchdog_periods = num_records * 50 + fir_pkg::num_taps + 100;

    logic                                clk;
    logic                                reset;
    logic                                sample_in_rdy;
    logic signed [fir_pkg::sample_w-1:0] sample_in_l;
    logic signed [fir_pkg::sample_w-1:0] sample_in_r;
    logic                                sample_out_rdy;
    logic signed [fir_pkg::sample_w-1:0] sample_out_l;
    logic signed [fir_pkg::sample_w-1:0] sample_out_r;

    // Per record: in_l in_r filtered_l filtered_r middle_l middle_r
    logic [fir_pkg::sample_w-1:0] vec [num_records*rec_words];

    int   errors;
    int   out_strobes;
    int   seed;
    logic first_in_sent;

    fir_interp_top dut_i (
        .clk            (clk),
        .reset          (reset),
        .sample_in_rdy  (sample_in_rdy),
        .sample_in_l    (sample_in_l),
        .sample_in_r    (sample_in_r),
        .sample_out_rdy (sample_out_rdy),
        .sample_out_l   (sample_out_l),
        .sample_out_r   (sample_out_r)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors = errors + 1;
            $display("CHECK FAILED at time %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // ------------------------------------------------------------------------
    // Output bus monitor, sampled on the falling edge
    // ------------------------------------------------------------------------
    always @(negedge clk) begin
        if (!reset) begin
            if (sample_out_rdy) begin
                out_strobes = out_strobes + 1;
                if (!first_in_sent) begin
                    errors = errors + 1;
                    $display("Output strobe at time %0t before any input sample was given",
                             $time);
                end
            end else begin
                check_value("idle sample_out_l", $unsigned(sample_out_l), '0);
                check_value("idle sample_out_r", $unsigned(sample_out_r), '0);
            end
        end
    end

    // One strobe in, then the filtered pair and the middle pair out
    task automatic run_record(input int rec);
        int base;
        int wait_cycles;
        base        = rec * rec_words;
        wait_cycles = 0;

        @(posedge clk);
        sample_in_rdy <= 1'b1;
        sample_in_l   <= vec[base];
        sample_in_r   <= vec[base+1];
        first_in_sent = 1'b1;
        @(posedge clk);
        sample_in_rdy <= 1'b0;
        sample_in_l   <= '0;
        sample_in_r   <= '0;

        // Counted from the accepting edge
        @(negedge clk);
        while (!sample_out_rdy && wait_cycles < max_latency) begin
            wait_cycles = wait_cycles + 1;
            @(negedge clk);
        end

        if (!sample_out_rdy) begin
            errors = errors + 1;
            $display("No output strobe within %0d cycles after input record %0d",
                     max_latency, rec);
        end else begin
            check_value($sformatf("record %0d latency", rec), wait_cycles, exp_latency);
            check_value($sformatf("record %0d filtered left", rec),
                        $unsigned(sample_out_l), vec[base+2]);
            check_value($sformatf("record %0d filtered right", rec),
                        $unsigned(sample_out_r), vec[base+3]);
            @(negedge clk);
            check_value($sformatf("record %0d second strobe", rec), sample_out_rdy, 1'b1);
            check_value($sformatf("record %0d middle left", rec),
                        $unsigned(sample_out_l), vec[base+4]);
            check_value($sformatf("record %0d middle right", rec),
                        $unsigned(sample_out_r), vec[base+5]);
            @(negedge clk);
            check_value($sformatf("record %0d third cycle strobe", rec), sample_out_rdy, 1'b0);
        end
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        int rec;
        int idle;
        errors        = 0;
        out_strobes   = 0;
        first_in_sent = 1'b0;
        seed          = 32'h13a0;
        reset         = 1'b1;
        sample_in_rdy = 1'b0;
        sample_in_l   = '0;
        sample_in_r   = '0;

        $readmemh("testbench/fir_interp_testdata.txt", vec);
        if ($isunknown(vec[num_records*rec_words-1])) begin
            errors = errors + 1;
            $display("Test data file is missing or holds fewer than %0d records", num_records);
        end

        repeat (2) @(posedge clk);
        reset <= 1'b0;

        // Init sweep clears the delay line, output stays quiet
        repeat (fir_pkg::num_taps + 4) @(negedge clk);

        for (rec = 0; rec < num_records; rec++) begin
            run_record(rec);
            idle = $unsigned($random(seed)) % 8;
            repeat (idle) @(posedge clk);
        end

        repeat (4) @(negedge clk);
        check_value("total output strobes", out_strobes, 2 * num_records);

        $display("Summary: %0d errors, %0d records, %0d output strobes",
                 errors, num_records, out_strobes);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        #(watchdog_periods * clk_period);
        $display("Timeout: run still going after %0d clock periods", watchdog_periods);
        $display("Test failures found");
        $finish;
    end

endmodule

// File: testbench/fir_interp_testdata.txt
// One record per line: in_l in_r filtered_l filtered_r middle_l middle_r
// 18-bit two's complement hex; filtered is acc[33:16], middle is half of the sample 16 back
10000 30000 3FFF8 00008 00000 00000
00000 00000 3FFE8 00018 00000 00000
00000 00000 3FFD0 00030 00000 00000
00000 00000 3FFC4 0003C 00000 00000
00000 00000 3FFD8 00028 00000 00000
00000 00000 00040 3FFC0 00000 00000
00000 00000 000B0 3FF50 00000 00000
00000 00000 000E4 3FF1C 00000 00000
00000 00000 000A8 3FF58 00000 00000
00000 00000 3FFC0 00040 00000 00000
00000 00000 3FE50 001B0 00000 00000
00000 00000 3FD10 002F0 00000 00000
00000 00000 3FD60 002A0 00000 00000
00000 00000 00120 3FEE0 00000 00000
00000 00000 00A40 3F5C0 00000 00000
00000 00000 01C80 3E380 00000 00000
00000 00000 02B10 3D4F0 08000 38000
00000 00000 02B10 3D4F0 00000 00000
00000 00000 01C80 3E380 00000 00000
00000 00000 00A40 3F5C0 00000 00000
00000 08000 00120 3FEDC 00000 00000
00000 00000 3FD60 00294 00000 00000
00000 00000 3FD10 002D8 00000 00000
00000 00000 3FE50 00192 00000 00000
00000 00000 3FFC0 0002C 00000 00000
00000 00000 000A8 3FF78 00000 00000
00000 00000 000E4 3FF74 00000 00000
00000 00000 000B0 3FFC2 00000 00000
00000 00000 00040 00014 00000 00000
00000 00000 3FFD8 00008 00000 00000
00000 00000 3FFC4 3FF64 00000 00000
00000 00000 3FFD0 3FEB8 00000 00000
00000 00000 3FFE8 3FEC8 00000 00000
00000 00000 3FFF8 00098 00000 00000
0C000 34000 3FFFA 00526 00000 00000
3C000 18000 3FFF0 00E46 00000 00000
14000 00000 3FFD8 01588 00000 04000
38000 2C000 3FFC5 01577 00000 00000
00000 00000 3FFC1 00E22 00000 00000
00000 00000 00007 004F0 00000 00000
00000 00000 00060 000B7 00000 00000
00000 00000 000E3 3FF3F 00000 00000
